// File: bench/pw_conv_checker.sv
module pw_conv_checker #(
	parameter int DEPTH = 8
) (
	input logic                         clk,
	input logic                         reset,
	input logic                         wr_en,
	input logic                         rd_en,
	input logic                         full,
	input logic                         empty,
	input logic [$clog2(DEPTH+1)-1:0]   count
);

	timeunit 1ns;
	timeprecision 100ps;

	// Assertion failures of this FIFO
	int fail_count = 0;

	// Occupancy rebuilt from the raw strobes
	// Spare top bit shows an overflow or an underflow wrap
	logic [$clog2(DEPTH+1):0] occupancy;

	always_ff @(posedge clk) begin
		if (reset) begin
			occupancy <= '0;
		end else begin
			occupancy <= occupancy + wr_en - rd_en;
		end
	end

	// Controller counting keeps writes off a full ring
	no_write_full: assert property (@(posedge clk) disable iff (reset) !(wr_en && full))
		else begin
			fail_count++;
			$error("Weight FIFO written while full");
		end

	// Recirculation refills the ring before each pop
	no_read_empty: assert property (@(posedge clk) disable iff (reset) !(rd_en && empty))
		else begin
			fail_count++;
			$error("Weight FIFO read while empty");
		end

	// Occupancy within the ring and matched by the FIFO count
	count_in_range: assert property (@(posedge clk) disable iff (reset)
		occupancy <= DEPTH && count == occupancy)
		else begin
			fail_count++;
			$error("Weight FIFO occupancy above depth or count off");
		end

endmodule

bind sync_fifo pw_conv_checker #(
	.DEPTH(DEPTH)
) u_checker (
	.clk  (clk),
	.reset(reset),
	.wr_en(wr_en),
	.rd_en(rd_en),
	.full (full),
	.empty(empty),
	.count(count)
);

// File: bench/pw_conv_monitor.sv
module pw_conv_monitor #(
	parameter int NUM_LANES = 4,
	parameter int CHANNELS  = 8
) (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               weight_valid,
	input  pw_conv_pkg::weight_t               weight_data,
	input  logic                               pixel_valid,
	input  pw_conv_pkg::pixel_t                pixel_data,
	input  logic                               weights_ready,
	input  logic                               result_valid,
	input  pw_conv_pkg::acc_t [NUM_LANES-1:0]  result,
	output int                                 error_count,
	output int                                 result_count,
	output int                                 pending
);

	timeunit 1ns;
	timeprecision 100ps;

	import pw_conv_pkg::*;

	localparam int TOTAL_WEIGHTS = NUM_LANES * CHANNELS;
	// Sampling edges from last pixel word to result_valid
	localparam int LATENCY = 2;

	// Weight table in accepted order, lane-major
	longint w_model [NUM_LANES][CHANNELS];
	int     w_count = 0;

	// Running sums of the pixel in flight
	longint sum_model [NUM_LANES];
	int     pix_ch = 0;

	// Expected sums, NUM_LANES entries per pixel
	longint exp_q [$];
	// Edge at which each pixel result is due
	int     due_q [$];

	int cycle  = 0;
	int errors = 0;
	int seen   = 0;
	int pend   = 0;

	assign error_count  = errors;
	assign result_count = seen;
	assign pending      = pend;

	////////////////////////////////////////////////////////////
	// Status and result compare
	////////////////////////////////////////////////////////////

	task automatic check_ready();
		// Level must track the accepted weight count
		if (weights_ready !== (w_count == TOTAL_WEIGHTS)) begin
			$display("Error at %0t: weights_ready is %b after %0d weights",
				$time, weights_ready, w_count);
			errors++;
		end
	endtask

	task automatic check_result();
		acc_t   got_word;
		longint got;
		if (due_q.size() != 0 && due_q[0] == cycle) begin
			if (result_valid !== 1'b1) begin
				$display("Error at %0t: result_valid missing for a finished pixel", $time);
				errors++;
			end else begin
				for (int k = 0; k < NUM_LANES; k++) begin
					got_word = result[k];
					got      = got_word;
					if (got != exp_q[k]) begin
						$display("Error at %0t: lane %0d result %0d expected %0d",
							$time, k, got, exp_q[k]);
						errors++;
					end
				end
				seen++;
			end
			void'(due_q.pop_front());
			repeat (NUM_LANES) void'(exp_q.pop_front());
		end else if (result_valid !== 1'b0) begin
			$display("Error at %0t: result_valid with no pixel finished", $time);
			errors++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	task automatic track_pixel();
		longint prod;
		// Only accepted once every lane holds its weights
		if (pixel_valid && w_count == TOTAL_WEIGHTS) begin
			for (int k = 0; k < NUM_LANES; k++) begin
				prod = longint'(pixel_data) * w_model[k][pix_ch];
				sum_model[k] = (pix_ch == 0) ? prod : sum_model[k] + prod;
			end
			if (pix_ch == CHANNELS - 1) begin
				for (int k = 0; k < NUM_LANES; k++) begin
					exp_q.push_back(sum_model[k]);
				end
				due_q.push_back(cycle + LATENCY);
				pix_ch = 0;
			end else begin
				pix_ch++;
			end
		end
	endtask

	task automatic track_weight();
		// Extra weights after the load are dropped
		if (weight_valid && w_count < TOTAL_WEIGHTS) begin
			w_model[w_count / CHANNELS][w_count % CHANNELS] = longint'(weight_data);
			w_count++;
		end
	endtask

	// Pixel before weight, so a pixel on the last load edge is not taken
	always @(posedge clk) begin
		if (reset) begin
			w_count = 0;
			pix_ch  = 0;
			exp_q.delete();
			due_q.delete();
		end else begin
			check_ready();
			check_result();
			track_pixel();
			track_weight();
		end
		pend = due_q.size();
		cycle++;
	end

endmodule

// File: bench/pw_conv_tb.sv
module pw_conv_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import pw_conv_pkg::*;

	localparam int NUM_LANES = 4;
	localparam int CHANNELS  = 8;
	// Cycle limit of any single wait
	localparam int WAIT_LIMIT = 200;
	// Pixels sent while weights are loaded
	localparam int PIXELS_SENT = 39;

	logic                 clk = 1'b0;
	logic                 reset;
	logic                 weight_valid;
	weight_t              weight_data;
	logic                 pixel_valid;
	pixel_t               pixel_data;
	logic                 weights_ready;
	logic                 result_valid;
	acc_t [NUM_LANES-1:0] result;

	// Monitor counters
	int error_count;
	int result_count;
	int pending;

	int          wait_errors;
	int          fifo_fails [NUM_LANES];
	int unsigned lcg_state;

	// 4 ns clock
	initial begin
		forever #2 clk = ~clk;
	end

	pw_conv_top #(
		.NUM_LANES(NUM_LANES),
		.CHANNELS (CHANNELS)
	) UUT (
		.clk          (clk),
		.reset        (reset),
		.weight_valid (weight_valid),
		.weight_data  (weight_data),
		.pixel_valid  (pixel_valid),
		.pixel_data   (pixel_data),
		.weights_ready(weights_ready),
		.result_valid (result_valid),
		.result       (result)
	);

	pw_conv_monitor #(
		.NUM_LANES(NUM_LANES),
		.CHANNELS (CHANNELS)
	) u_monitor (
		.clk          (clk),
		.reset        (reset),
		.weight_valid (weight_valid),
		.weight_data  (weight_data),
		.pixel_valid  (pixel_valid),
		.pixel_data   (pixel_data),
		.weights_ready(weights_ready),
		.result_valid (result_valid),
		.result       (result),
		.error_count  (error_count),
		.result_count (result_count),
		.pending      (pending)
	);

	// Assertion failures of each bound FIFO checker
	for (genvar k = 0; k < NUM_LANES; k++) begin : g_fifo_watch
		assign fifo_fails[k] = UUT.g_lane[k].u_buffer.u_fifo.u_checker.fail_count;
	end

	////////////////////////////////////////////////////////////
	// Stimulus helpers, all driven on the falling edge
	////////////////////////////////////////////////////////////

	function automatic logic [15:0] next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[30:15];
	endfunction

	task automatic idle_gap();
		int gap;
		// Mostly no gap, sometimes one or two idle cycles
		gap = int'(next_random() % 16'd8);
		if (gap > 2) begin
			gap = 0;
		end
		repeat (gap) @(negedge clk);
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		repeat (4) @(negedge clk);
		reset = 1'b0;
	endtask

	task automatic send_weight(input bit gaps);
		if (gaps) begin
			idle_gap();
		end
		weight_valid = 1'b1;
		weight_data  = weight_t'(next_random());
		@(negedge clk);
		weight_valid = 1'b0;
	endtask

	task automatic send_pixel_word(input bit gaps);
		if (gaps) begin
			idle_gap();
		end
		pixel_valid = 1'b1;
		pixel_data  = pixel_t'(next_random());
		@(negedge clk);
		pixel_valid = 1'b0;
	endtask

	// One pixel is CHANNELS words, channel 0 first
	task automatic send_pixel(input bit gaps);
		for (int c = 0; c < CHANNELS; c++) begin
			send_pixel_word(gaps);
		end
	endtask

	task automatic wait_ready();
		int cycles;
		cycles = 0;
		while (weights_ready !== 1'b1 && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		if (weights_ready !== 1'b1) begin
			$display("Timeout: weights_ready never rose after the weight load");
			wait_errors++;
		end
	endtask

	task automatic load_all_weights(input bit gaps);
		repeat (NUM_LANES * CHANNELS) send_weight(gaps);
		wait_ready();
	endtask

	task automatic wait_results();
		int cycles;
		cycles = 0;
		while (pending != 0 && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		if (pending != 0) begin
			$display("Timeout: %0d pixel results never came out", pending);
			wait_errors++;
		end
	endtask

	task automatic report();
		int fifo_total;
		int total;
		fifo_total = 0;
		foreach (fifo_fails[k]) begin
			fifo_total += fifo_fails[k];
		end
		if (result_count != PIXELS_SENT) begin
			$display("Only %0d of %0d pixel results were checked", result_count, PIXELS_SENT);
			wait_errors++;
		end
		total = error_count + wait_errors + fifo_total;
		$display("Results %0d, compare errors %0d, other errors %0d, FIFO check failures %0d",
			result_count, error_count, wait_errors, fifo_total);
		if (total == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin
		lcg_state    = 73;
		wait_errors  = 0;
		reset        = 1'b1;
		weight_valid = 1'b0;
		weight_data  = '0;
		pixel_valid  = 1'b0;
		pixel_data   = '0;
		apply_reset();
		// Pixel words during load are dropped
		repeat (3) send_pixel_word(1'b0);
		load_all_weights(1'b1);
		// Late weights must not touch the rings
		repeat (5) send_weight(1'b0);
		send_pixel(1'b0);
		wait_results();
		// Back to back, rings go round many times
		repeat (20) send_pixel(1'b0);
		wait_results();
		repeat (10) send_pixel(1'b1);
		wait_results();
		// Second reset and a fresh set of weights
		apply_reset();
		load_all_weights(1'b0);
		repeat (8) send_pixel(1'b1);
		wait_results();
		report();
	end

endmodule

// File: logic/conv_1x1_weight_buffer.sv
module conv_1x1_weight_buffer #(
	parameter int CHANNELS = 8
) (
	input  logic                clk,
	input  logic                reset,
	input  logic                valid_in,
	input  pw_conv_pkg::weight_t in,
	input  logic                load_weights,
	output pw_conv_pkg::weight_t out_buffer_weight
);

	import pw_conv_pkg::*;

	// Input register stage
	weight_t in_reg;
	logic    in_reg_valid;

	// Read happened last cycle, word at the output goes back in
	logic recirc;

	////////////////////////////////////////////////////////////
	// Input register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			recirc       <= 1'b0;
			in_reg_valid <= 1'b0;
		end else begin
			recirc       <= load_weights;
			// Either a fresh weight or a recirculated one
			in_reg_valid <= valid_in || recirc;
		end
	end

	// Recirculation mux
	// Load and compute never overlap so the two sources never collide
	always_ff @(posedge clk) begin
		if (recirc) begin
			in_reg <= out_buffer_weight;
		end else if (valid_in) begin
			in_reg <= in;
		end
	end

	////////////////////////////////////////////////////////////
	// Weight FIFO
	////////////////////////////////////////////////////////////

	// Holds a ring of CHANNELS weights in channel order
	// Read word is back at the tail two edges after it leaves
	sync_fifo #(
		.WIDTH(WEIGHT_W),
		.DEPTH(CHANNELS)
	) u_fifo (
		.clk  (clk),
		.reset(reset),
		.wr_en(in_reg_valid),
		.din  (in_reg),
		.rd_en(load_weights),
		.dout (out_buffer_weight)
	);

endmodule

// File: logic/pw_conv_ctrl.sv
module pw_conv_ctrl #(
	parameter int NUM_LANES = 4,
	parameter int CHANNELS  = 8
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 weight_valid,
	input  pw_conv_pkg::weight_t weight_data,
	input  logic                 pixel_valid,
	input  pw_conv_pkg::pixel_t  pixel_data,
	output logic [NUM_LANES-1:0] wr_en,
	output pw_conv_pkg::weight_t wr_data,
	output logic                 load_weights,
	output pw_conv_pkg::mac_op_t mac_op,
	output logic                 weights_ready,
	output logic                 result_valid
);

	import pw_conv_pkg::*;

	// Counter widths
	localparam int LANE_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
	localparam int CH_W   = $clog2(CHANNELS);

	ctrl_state_t state;

	// Load side counters
	logic [LANE_W-1:0] load_lane;
	logic [CH_W-1:0]   load_ch;

	// Pixel side channel counter
	logic [CH_W-1:0] pix_ch;

	// One-hot lane select
	logic [NUM_LANES-1:0] lane_sel;

	// Accepted strobes
	logic weight_acc;
	logic pixel_acc;

	// Counter end flags
	logic load_ch_last;
	logic load_lane_last;
	logic pix_first;
	logic pix_last;

	////////////////////////////////////////////////////////////
	// Strobe gating and steering
	////////////////////////////////////////////////////////////

	// Strobes in the wrong state are dropped
	assign weight_acc = weight_valid && (state == ST_LOAD);
	assign pixel_acc  = pixel_valid && (state == ST_COMPUTE);

	// Weight goes to the lane being filled
	assign lane_sel = NUM_LANES'(1) << load_lane;
	assign wr_en    = weight_acc ? lane_sel : '0;
	assign wr_data  = weight_data;

	// Every buffer pops together with the pixel word
	assign load_weights = pixel_acc;

	assign weights_ready = (state == ST_COMPUTE);

	assign load_ch_last   = (load_ch == CH_W'(CHANNELS - 1));
	assign load_lane_last = (load_lane == LANE_W'(NUM_LANES - 1));
	assign pix_first      = (pix_ch == '0);
	assign pix_last       = (pix_ch == CH_W'(CHANNELS - 1));

	////////////////////////////////////////////////////////////
	// FSM and load counters
	////////////////////////////////////////////////////////////

	// Lane-major fill, channel counter runs fastest
	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= ST_LOAD;
			load_lane <= '0;
			load_ch   <= '0;
		end else if (weight_acc) begin
			load_ch <= load_ch_last ? '0 : load_ch + 1'b1;
			if (load_ch_last) begin
				load_lane <= load_lane_last ? '0 : load_lane + 1'b1;
				// Last weight of last lane, stay in compute until reset
				if (load_lane_last) begin
					state <= ST_COMPUTE;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Pixel channel count and op register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			pix_ch <= '0;
		end else if (pixel_acc) begin
			pix_ch <= pix_last ? '0 : pix_ch + 1'b1;
		end
	end

	// Op lines up with the buffer outputs one cycle after the pop
	always_ff @(posedge clk) begin
		if (reset) begin
			mac_op.valid <= 1'b0;
			mac_op.first <= 1'b0;
			mac_op.last  <= 1'b0;
			result_valid <= 1'b0;
		end else begin
			mac_op.valid <= pixel_acc;
			mac_op.first <= pixel_acc && pix_first;
			mac_op.last  <= pixel_acc && pix_last;
			// Lanes latch their sums on the same edge
			result_valid <= mac_op.valid && mac_op.last;
			if (pixel_acc) begin
				mac_op.pixel <= pixel_data;
			end
		end
	end

endmodule

// File: logic/pw_conv_pkg.sv
package pw_conv_pkg;

	////////////////////////////////////////////////////////////
	// Data widths
	////////////////////////////////////////////////////////////

	// Input activation width
	localparam int PIXEL_W = 16;
	// Weight width
	localparam int WEIGHT_W = 16;
	// Full product of one pixel and one weight
	localparam int PROD_W = PIXEL_W + WEIGHT_W;
	// Accumulator width, room for 256 full scale products
	localparam int ACC_W = 40;

	////////////////////////////////////////////////////////////
	// Word types
	////////////////////////////////////////////////////////////

	typedef logic signed [PIXEL_W-1:0] pixel_t;
	typedef logic signed [WEIGHT_W-1:0] weight_t;
	typedef logic signed [PROD_W-1:0] prod_t;
	typedef logic signed [ACC_W-1:0] acc_t;

	// Op broadcast to every lane, one per accepted pixel word
	typedef struct packed {
		// Cycle carries a channel product
		logic valid;
		// Restart the sum
		logic first;
		// Close the sum and latch the result
		logic last;
		// Pixel word aligned with the buffer outputs
		pixel_t pixel;
	} mac_op_t;

	// Controller states
	typedef enum logic {
		// Accepting weights
		ST_LOAD,
		// Accepting pixels
		ST_COMPUTE
	} ctrl_state_t;

endpackage

// File: logic/pw_conv_top.sv
module pw_conv_top #(
	parameter int NUM_LANES = 4,
	parameter int CHANNELS  = 8
) (
	input  logic                                  clk,
	input  logic                                  reset,
	input  logic                                  weight_valid,
	input  pw_conv_pkg::weight_t                  weight_data,
	input  logic                                  pixel_valid,
	input  pw_conv_pkg::pixel_t                   pixel_data,
	output logic                                  weights_ready,
	output logic                                  result_valid,
	output pw_conv_pkg::acc_t [NUM_LANES-1:0]     result
);

	import pw_conv_pkg::*;

	// Controller to buffers
	logic [NUM_LANES-1:0] wr_en;
	weight_t              wr_data;
	logic                 load_weights;

	// Controller to lanes
	mac_op_t mac_op;

	// Buffer output per lane
	weight_t lane_weight [NUM_LANES];

	////////////////////////////////////////////////////////////
	// Controller
	////////////////////////////////////////////////////////////

	pw_conv_ctrl #(
		.NUM_LANES(NUM_LANES),
		.CHANNELS (CHANNELS)
	) u_ctrl (
		.clk          (clk),
		.reset        (reset),
		.weight_valid (weight_valid),
		.weight_data  (weight_data),
		.pixel_valid  (pixel_valid),
		.pixel_data   (pixel_data),
		.wr_en        (wr_en),
		.wr_data      (wr_data),
		.load_weights (load_weights),
		.mac_op       (mac_op),
		.weights_ready(weights_ready),
		.result_valid (result_valid)
	);

	////////////////////////////////////////////////////////////
	// Lanes, one per output channel
	////////////////////////////////////////////////////////////

	for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
		// Weight ring for output channel k
		conv_1x1_weight_buffer #(
			.CHANNELS(CHANNELS)
		) u_buffer (
			.clk              (clk),
			.reset            (reset),
			.valid_in         (wr_en[k]),
			.in               (wr_data),
			.load_weights     (load_weights),
			.out_buffer_weight(lane_weight[k])
		);

		// MAC for output channel k
		pw_mac_lane u_lane (
			.clk   (clk),
			.reset (reset),
			.mac_op(mac_op),
			.weight(lane_weight[k]),
			.result(result[k])
		);
	end

endmodule

// File: logic/pw_mac_lane.sv
module pw_mac_lane (
	input  logic                 clk,
	input  logic                 reset,
	input  pw_conv_pkg::mac_op_t mac_op,
	input  pw_conv_pkg::weight_t weight,
	output pw_conv_pkg::acc_t    result
);

	import pw_conv_pkg::*;

	// Pixel pulled out of the op as a signed word
	pixel_t pixel;

	// Channel product
	prod_t prod;

	// Sum start value and updated sum
	acc_t sum_base;
	acc_t sum_next;

	// Running sum
	acc_t acc;

	assign pixel = mac_op.pixel;

	////////////////////////////////////////////////////////////
	// Multiply and add
	////////////////////////////////////////////////////////////

	// Signed 16x16 product in full width
	assign prod = pixel * weight;

	// First channel drops the old sum
	assign sum_base = mac_op.first ? '0 : acc;

	// Sign extended product into the accumulator
	assign sum_next = sum_base + acc_t'(prod);

	////////////////////////////////////////////////////////////
	// Accumulator and result
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			acc    <= '0;
			result <= '0;
		end else if (mac_op.valid) begin
			acc <= sum_next;
			// Last channel closes the pixel
			if (mac_op.last) begin
				result <= sum_next;
			end
		end
	end

	// Result holds until the next last

endmodule

// File: logic/sync_fifo.sv
module sync_fifo #(
	parameter int WIDTH = 16,
	parameter int DEPTH = 8
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             wr_en,
	input  logic [WIDTH-1:0] din,
	input  logic             rd_en,
	output logic [WIDTH-1:0] dout
);

	// Pointer and occupancy widths
	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	// Storage
	logic [WIDTH-1:0] mem [DEPTH];

	// Pointers and occupancy
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;

	// Status, only seen by bound checks
	logic full;
	logic empty;

	// Qualified strobes
	logic wr_ok;
	logic rd_ok;

	// Wrap at DEPTH-1 so any depth works
	function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
		return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign full  = (count == CW'(DEPTH));
	assign empty = (count == '0);

	// Overflow and underflow are dropped
	assign wr_ok = wr_en && !full;
	assign rd_ok = rd_en && !empty;

	////////////////////////////////////////////////////////////
	// Pointers and count
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_ok) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (rd_ok) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			// Simultaneous read and write leaves count alone
			case ({wr_ok, rd_ok})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Memory and output word
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (wr_ok) begin
			mem[wr_ptr] <= din;
		end
		// Output word updates only on a read
		if (rd_ok) begin
			dout <= mem[rd_ptr];
		end
	end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the pointwise convolution testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module pw_conv_tb -f vlog.f -o pw_conv_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/pw_conv_sim +verilator+error+limit+100 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Errors found" "$log"; then
	echo "Simulation reported failures"
	exit 1
fi

echo "Simulation finished cleanly"
exit 0

// File: vlog.f
logic/pw_conv_pkg.sv
logic/sync_fifo.sv
logic/conv_1x1_weight_buffer.sv
logic/pw_mac_lane.sv
logic/pw_conv_ctrl.sv
logic/pw_conv_top.sv
bench/pw_conv_checker.sv
bench/pw_conv_monitor.sv
bench/pw_conv_tb.sv
